//--- sim.f
rtl/cpu_pkg.sv
rtl/cache_pkg.sv
rtl/block_ram.sv
rtl/cache_memory.sv
rtl/load_controller.sv
rtl/memory_bridge.sv
rtl/dcache_load_path.sv
verification/wb_memory_model.sv
verification/tb_dcache_load_path.sv

//--- Makefile
TOP := tb_dcache_load_path

.PHONY: simulate clean

# The run passes only if the log holds the pass line.
simulate:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verification/tb_dcache_load_path.sv
`default_nettype none

module tb_dcache_load_path
    import cpu_pkg::*;
    import cache_pkg::*;
();

    localparam int NUM_SETS      = 16;
    localparam int BLOCK_WORDS   = 4;
    localparam int CLK_PERIOD    = 20;
    localparam int SEED          = 63295;
    localparam data_word_t PATTERN_KEY = 32'h5A3C_96E1;  // Memory word A starts as A ^ key.
    localparam int FIXED_ROWS    = 9;
    localparam int RANDOM_ROWS   = 40;
    localparam int ROWS          = FIXED_ROWS + RANDOM_ROWS;
    localparam int MISS_BOUND    = 80;  // Cycles, above a dirty miss with the longest waits.
    localparam int WATCHDOG_TIME = (ROWS + 4) * MISS_BOUND * CLK_PERIOD;
    localparam int SET_SHIFT     = BYTE_OFFSET_BITS + $clog2(BLOCK_WORDS);
    localparam int TAG_SHIFT     = SET_SHIFT + $clog2(NUM_SETS);
    localparam logic LOAD        = 1'b0;
    localparam logic STORE       = 1'b1;

    logic clk_i;
    logic rst_n_i;
    logic request_i, valid_o;
    data_word_t address_i, data_o;
    logic store_valid_i, store_ack_o, store_hit_o;
    data_word_t store_address_i, store_data_i;
    logic wb_cyc_o, wb_stb_o, wb_we_o, wb_ack_i;
    data_word_t wb_adr_o, wb_dat_o, wb_dat_i;

    // Stimulus columns first, then the expected columns filled by the shadow model.
    logic row_store [ROWS];
    data_word_t row_addr [ROWS];
    data_word_t row_data [ROWS];
    logic exp_hit [ROWS];
    logic exp_wb [ROWS];  // The load evicts a dirty block.
    data_word_t exp_word [ROWS];
    data_word_t exp_victim [ROWS];  // Base address of the evicted block.
    data_word_t exp_wb_data [ROWS][BLOCK_WORDS];
    int row_count = 0;

    data_word_t mem_shadow [data_word_t];  // Words that write-backs have changed.
    data_word_t cache_data [NUM_SETS][BLOCK_WORDS];
    data_word_t cache_tag [NUM_SETS];
    logic cache_valid [NUM_SETS];
    logic cache_dirty [NUM_SETS];

    data_word_t read_adrs[$], write_adrs[$], write_dats[$];  // Observed Wishbone traffic.
    int checks = 0;
    int errors = 0;

    dcache_load_path #(.NUM_SETS(NUM_SETS), .BLOCK_WORDS(BLOCK_WORDS)) dut (
        .clk_i, .rst_n_i, .request_i, .address_i, .data_o, .valid_o,
        .store_valid_i, .store_address_i, .store_data_i, .store_ack_o, .store_hit_o,
        .wb_cyc_o, .wb_stb_o, .wb_we_o, .wb_adr_o, .wb_dat_o, .wb_dat_i, .wb_ack_i
    );

    wb_memory_model #(.PATTERN_KEY(PATTERN_KEY)) memory (
        .clk_i, .rst_n_i, .wb_cyc_i(wb_cyc_o), .wb_stb_i(wb_stb_o), .wb_we_i(wb_we_o),
        .wb_adr_i(wb_adr_o), .wb_dat_i(wb_dat_o), .wb_dat_o(wb_dat_i), .wb_ack_o(wb_ack_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired at %0t, the test sequence did not complete.", $time);
        $display("STATUS: FAIL");
        $finish;
    end

    // With ack high at the falling edge the transfer ends on the next rising edge.
    always @(negedge clk_i) begin
        if (wb_cyc_o && wb_stb_o && wb_ack_i) begin
            if (wb_we_o) begin
                write_adrs.push_back(wb_adr_o);
                write_dats.push_back(wb_dat_o);
            end else begin
                read_adrs.push_back(wb_adr_o);
            end
        end
    end

    function automatic int set_index(input data_word_t a);
        return int'((a >> SET_SHIFT) % NUM_SETS);
    endfunction

    function automatic int word_index(input data_word_t a);
        return int'((a >> BYTE_OFFSET_BITS) % BLOCK_WORDS);
    endfunction

    function automatic data_word_t tag_field(input data_word_t a);
        return a >> TAG_SHIFT;
    endfunction

    function automatic data_word_t block_base(input data_word_t t, input int s);
        return (t << TAG_SHIFT) | (data_word_t'(s) << SET_SHIFT);
    endfunction

    function automatic data_word_t memory_value(input data_word_t a);
        return mem_shadow.exists(a) ? mem_shadow[a] : (a ^ PATTERN_KEY);
    endfunction

    task automatic check_word(input string name, input data_word_t actual,
                              input data_word_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic check_status(input string name, input status_packet_t actual,
                                input status_packet_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic add_row(input logic kind, input data_word_t a, input data_word_t d);
        row_store[row_count] = kind;
        row_addr[row_count]  = a;
        row_data[row_count]  = d;
        row_count++;
    endtask

    task automatic build_table();
        int s;
        int w;
        data_word_t t;
        add_row(LOAD,  32'h0000_1024, '0);            // Cold miss in set 2.
        add_row(LOAD,  32'h0000_102C, '0);            // Same block, so a hit.
        add_row(STORE, 32'h0000_1028, 32'hCAFE_0001); // Store hit makes set 2 dirty.
        add_row(LOAD,  32'h0000_1028, '0);            // Returns the stored word.
        add_row(STORE, 32'h0000_3040, 32'h1234_5678); // Set 4 is empty, so nothing changes.
        add_row(LOAD,  32'h0000_3040, '0);            // Still the pattern word.
        add_row(LOAD,  32'h0000_2024, '0);            // Dirty conflict in set 2.
        add_row(LOAD,  32'h0000_1028, '0);            // Clean conflict, stored word from memory.
        add_row(LOAD,  32'h0000_5044, '0);            // Clean conflict in set 4.
        for (int r = 0; r < RANDOM_ROWS; r++) begin
            s = 3 + 4 * int'($urandom % 3);             // Sets 3, 7 and 11.
            t = 32'h40 + ($urandom % 3);                // Three tags compete for each set.
            w = int'($urandom % BLOCK_WORDS);
            add_row(1'($urandom % 2), block_base(t, s) + data_word_t'(4 * w), $urandom);
        end
    endtask

    // Direct-mapped rule: one block per set, write-back only when the victim is dirty.
    task automatic predict_row(input int i);
        int s;
        int w;
        data_word_t t;
        s = set_index(row_addr[i]);
        w = word_index(row_addr[i]);
        t = tag_field(row_addr[i]);
        exp_hit[i]    = cache_valid[s] && (cache_tag[s] == t);
        exp_wb[i]     = !row_store[i] && !exp_hit[i] && cache_valid[s] && cache_dirty[s];
        exp_victim[i] = block_base(cache_tag[s], s);
        if (row_store[i]) begin
            if (exp_hit[i]) begin
                cache_data[s][w] = row_data[i];
                cache_dirty[s]   = 1'b1;
            end
        end else begin
            for (int k = 0; k < BLOCK_WORDS; k++) begin
                exp_wb_data[i][k] = cache_data[s][k];
                if (exp_wb[i]) mem_shadow[exp_victim[i] + data_word_t'(4 * k)] = cache_data[s][k];
            end
            if (!exp_hit[i]) begin
                for (int k = 0; k < BLOCK_WORDS; k++) begin
                    cache_data[s][k] = memory_value(block_base(t, s) + data_word_t'(4 * k));
                end
                cache_tag[s]   = t;
                cache_valid[s] = 1'b1;
                cache_dirty[s] = 1'b0;
            end
            exp_word[i] = cache_data[s][w];
        end
    endtask

    task automatic apply_load(input int i);
        int cycles;
        data_word_t base;
        status_packet_t seen;
        status_packet_t want;
        base = block_base(tag_field(row_addr[i]), set_index(row_addr[i]));
        read_adrs.delete();
        write_adrs.delete();
        write_dats.delete();
        @(negedge clk_i);
        request_i = 1'b1;
        address_i = row_addr[i];
        @(negedge clk_i);  // Sampled on the rising edge in between.
        request_i = 1'b0;
        check_bit("valid_o one cycle after request_i", valid_o, exp_hit[i]);
        cycles = 0;
        while (!valid_o && cycles < MISS_BOUND) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!valid_o) begin
            errors++;
            $display("Row %0d: no load result arrived within %0d cycles.", i, MISS_BOUND);
        end else begin
            check_word("data_o", data_o, exp_word[i]);
        end
        seen.valid = (read_adrs.size() != 0);  // Refill seen.
        seen.dirty = (write_adrs.size() != 0); // Write-back seen.
        want.valid = !exp_hit[i];
        want.dirty = exp_wb[i];
        check_status("Wishbone activity", seen, want);
        check_word("Wishbone read count", data_word_t'(read_adrs.size()),
                   data_word_t'(exp_hit[i] ? 0 : BLOCK_WORDS));
        check_word("Wishbone write count", data_word_t'(write_adrs.size()),
                   data_word_t'(exp_wb[i] ? BLOCK_WORDS : 0));
        for (int k = 0; k < read_adrs.size() && k < BLOCK_WORDS; k++) begin
            check_word("wb_adr_o on refill", read_adrs[k], base + data_word_t'(4 * k));
        end
        for (int k = 0; k < write_adrs.size() && k < BLOCK_WORDS; k++) begin
            check_word("wb_adr_o on write-back", write_adrs[k],
                       exp_victim[i] + data_word_t'(4 * k));
            check_word("wb_dat_o on write-back", write_dats[k], exp_wb_data[i][k]);
        end
    endtask

    task automatic apply_store(input int i);
        int cycles;
        @(negedge clk_i);
        store_valid_i   = 1'b1;
        store_address_i = row_addr[i];
        store_data_i    = row_data[i];
        @(negedge clk_i);  // The controller is idle, so the store is taken at once.
        check_bit("store_ack_o one cycle after store_valid_i", store_ack_o, 1'b1);
        cycles = 0;
        while (!store_ack_o && cycles < MISS_BOUND) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!store_ack_o) begin
            errors++;
            $display("Row %0d: the store was never acknowledged.", i);
        end else begin
            check_bit("store_hit_o", store_hit_o, exp_hit[i]);
        end
        store_valid_i = 1'b0;
    endtask

    initial begin
        int errors_before;
        void'($urandom(SEED));
        rst_n_i         = 1'b0;
        request_i       = 1'b0;
        address_i       = '0;
        store_valid_i   = 1'b0;
        store_address_i = '0;
        store_data_i    = '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            cache_tag[s]   = '0;
            cache_valid[s] = 1'b0;  // The cache starts empty.
            cache_dirty[s] = 1'b0;
        end
        build_table();
        for (int i = 0; i < ROWS; i++) predict_row(i);
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        check_bit("valid_o after reset", valid_o, 1'b0);
        check_bit("store_ack_o after reset", store_ack_o, 1'b0);
        check_bit("wb_cyc_o after reset", wb_cyc_o, 1'b0);
        check_bit("wb_stb_o after reset", wb_stb_o, 1'b0);
        $display("Reset state: %s", (errors == 0) ? "ok" : "mismatch");
        for (int i = 0; i < ROWS; i++) begin
            errors_before = errors;
            if (row_store[i]) apply_store(i);
            else apply_load(i);
            $display("Row %0d: %s 0x%08h, expected %s, %s", i, row_store[i] ? "store" : "load",
                     row_addr[i], exp_hit[i] ? "hit" : "miss",
                     (errors == errors_before) ? "ok" : "mismatch");
        end
        $display("Finished %0d tests with %0d checks and %0d errors", ROWS + 1, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule : tb_dcache_load_path

`default_nettype wire

//--- verification/wb_memory_model.sv
`default_nettype none

module wb_memory_model
    import cpu_pkg::*;
#(
    parameter data_word_t PATTERN_KEY = 32'h0,  // Unwritten word A reads as A ^ key.
    parameter int         MAX_WAIT    = 2       // Wait states are drawn from 0 to this.
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       wb_cyc_i,
    input  logic       wb_stb_i,
    input  logic       wb_we_i,
    input  data_word_t wb_adr_i,
    input  data_word_t wb_dat_i,
    output data_word_t wb_dat_o,
    output logic       wb_ack_o
);

    data_word_t mem [data_word_t];  // Only words written by the master are stored.
    int wait_q;                     // Wait states left before the next acknowledge.

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_ack_o <= 1'b0;
            wb_dat_o <= '0;
            wait_q   <= 0;
        end else begin
            wb_ack_o <= 1'b0;  // The acknowledge lasts a single cycle.
            if (wb_cyc_i && wb_stb_i && !wb_ack_o) begin
                if (wait_q != 0) begin
                    wait_q <= wait_q - 1;  // Stretch the bus cycle.
                end else begin
                    wb_ack_o <= 1'b1;
                    wait_q   <= int'($urandom % (MAX_WAIT + 1));  // Delay for the next cycle.
                    if (wb_we_i) begin
                        mem[wb_adr_i] = wb_dat_i;
                    end else begin
                        wb_dat_o <= mem.exists(wb_adr_i) ? mem[wb_adr_i] : (wb_adr_i ^ PATTERN_KEY);
                    end
                end
            end
        end
    end

endmodule : wb_memory_model

`default_nettype wire

//--- rtl/dcache_load_path.sv
`default_nettype none

module dcache_load_path
    import cpu_pkg::*;
    import cache_pkg::*;
#(
    parameter int NUM_SETS    = 16,  // Direct-mapped, one block per set.
    parameter int BLOCK_WORDS = 4
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic request_i,
    input  data_word_t address_i,
    output data_word_t data_o,
    output logic valid_o,
    input  logic store_valid_i,
    input  data_word_t store_address_i,
    input  data_word_t store_data_i,
    output logic store_ack_o,
    output logic store_hit_o,
    output logic wb_cyc_o,
    output logic wb_stb_o,
    output logic wb_we_o,
    output data_word_t wb_adr_o,
    output data_word_t wb_dat_o,
    input  data_word_t wb_dat_i,
    input  logic wb_ack_i
);

    localparam int TAG_BITS = WORD_ADDR_BITS - $clog2(NUM_SETS) - $clog2(BLOCK_WORDS);

    data_word_t address, store_data, memory_data, cache_data;
    logic load_request, store_request, load_done, store_done;
    logic cache_hit, cache_load_request, cache_store_request, controller_idle;
    logic [TAG_BITS-1:0] cache_tag;
    status_packet_t status_rd, status_wr;  // Lookup result and refill status.
    enable_t enable_write;

    load_controller #(.NUM_SETS(NUM_SETS), .BLOCK_WORDS(BLOCK_WORDS)) controller (
        .clk_i, .rst_n_i, .request_i, .address_i, .data_o, .valid_o,
        .address_o(address), .store_data_o(store_data),
        .load_done_i(load_done), .memory_data_i(memory_data), .load_request_o(load_request),
        .store_done_i(store_done), .store_request_o(store_request),
        .cache_hit_i(cache_hit), .cache_tag_i(cache_tag),
        .cache_status_i(status_rd), .cache_status_o(status_wr),
        .cache_data_i(cache_data), .enable_write_o(enable_write),
        .cache_load_request_o(cache_load_request), .cache_store_request_o(cache_store_request),
        .controller_idle_o(controller_idle)
    );

    cache_memory #(.NUM_SETS(NUM_SETS), .BLOCK_WORDS(BLOCK_WORDS)) cache (
        .clk_i, .rst_n_i, .address_i(address),
        .cache_load_request_i(cache_load_request), .cache_store_request_i(cache_store_request),
        .enable_write_i(enable_write), .write_data_i(store_data), .status_i(status_wr),
        .controller_idle_i(controller_idle),
        .store_valid_i, .store_address_i, .store_data_i,
        .cache_hit_o(cache_hit), .cache_tag_o(cache_tag),
        .cache_status_o(status_rd), .cache_data_o(cache_data),
        .store_ack_o, .store_hit_o
    );

    memory_bridge bridge (
        .clk_i, .rst_n_i, .address_i(address), .store_data_i(store_data),
        .load_request_i(load_request), .store_request_i(store_request),
        .load_done_o(load_done), .store_done_o(store_done), .memory_data_o(memory_data),
        .wb_cyc_o, .wb_stb_o, .wb_we_o, .wb_adr_o, .wb_dat_o, .wb_dat_i, .wb_ack_i
    );

endmodule : dcache_load_path

`default_nettype wire

//--- rtl/memory_bridge.sv
`default_nettype none

module memory_bridge
    import cpu_pkg::*;
(
    input  logic clk_i,
    input  logic rst_n_i,
    input  data_word_t address_i,
    input  data_word_t store_data_i,
    input  logic load_request_i,
    input  logic store_request_i,
    output logic load_done_o,
    output logic store_done_o,
    output data_word_t memory_data_o,
    // Wishbone classic master.
    output logic wb_cyc_o,
    output logic wb_stb_o,
    output logic wb_we_o,
    output data_word_t wb_adr_o,
    output data_word_t wb_dat_o,
    input  data_word_t wb_dat_i,
    input  logic wb_ack_i
);

    typedef enum logic [1:0] {BRIDGE_IDLE, BRIDGE_BUSY, BRIDGE_DONE} bridge_state_t;

    bridge_state_t state_q;
    logic we_q;
    data_word_t adr_q, dat_q, rdata_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= BRIDGE_IDLE;
            we_q    <= 1'b0;
        end else begin
            case (state_q)
                BRIDGE_IDLE: if (load_request_i || store_request_i) begin
                    state_q <= BRIDGE_BUSY;
                    we_q    <= store_request_i;
                end
                BRIDGE_BUSY: if (wb_ack_i) state_q <= BRIDGE_DONE;  // Wait states stretch here.
                default:     state_q <= BRIDGE_IDLE;  // Done lasts one cycle.
            endcase
        end
    end

    // Transfer register, loaded while idle so it holds through the bus cycle.
    always_ff @(posedge clk_i) begin
        if (state_q == BRIDGE_IDLE) begin
            adr_q <= address_i;
            dat_q <= store_data_i;
        end
        if (state_q == BRIDGE_BUSY && wb_ack_i) begin
            rdata_q <= wb_dat_i;  // Read data is only valid with the acknowledge.
        end
    end

    assign wb_cyc_o = (state_q == BRIDGE_BUSY);
    assign wb_stb_o = (state_q == BRIDGE_BUSY);
    assign wb_we_o  = we_q;
    assign wb_adr_o = adr_q;
    assign wb_dat_o = dat_q;

    assign load_done_o   = (state_q == BRIDGE_DONE) & ~we_q;
    assign store_done_o  = (state_q == BRIDGE_DONE) & we_q;
    assign memory_data_o = rdata_q;

    // Only one transfer may be asked for at a time.
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(load_request_i && store_request_i));

endmodule : memory_bridge

`default_nettype wire

//--- rtl/load_controller.sv
`default_nettype none

module load_controller
    import cpu_pkg::*;
    import cache_pkg::*;
#(
    parameter int NUM_SETS    = 16,
    parameter int BLOCK_WORDS = 4
) (
    input  logic clk_i,
    input  logic rst_n_i,
    // Load unit.
    input  logic request_i,
    input  data_word_t address_i,
    output data_word_t data_o,
    output logic valid_o,
    // Shared by the cache and the memory bridge.
    output data_word_t address_o,
    output data_word_t store_data_o,
    // Memory load and store.
    input  logic load_done_i,
    input  data_word_t memory_data_i,
    output logic load_request_o,
    input  logic store_done_i,
    output logic store_request_o,
    // Cache arrays.
    input  logic cache_hit_i,
    input  logic [XLEN-BYTE_OFFSET_BITS-$clog2(NUM_SETS)-$clog2(BLOCK_WORDS)-1:0] cache_tag_i,
    input  status_packet_t cache_status_i,
    output status_packet_t cache_status_o,
    input  data_word_t cache_data_i,
    output enable_t enable_write_o,
    output logic cache_load_request_o,
    output logic cache_store_request_o,
    output logic controller_idle_o
);

    localparam int WORD_BITS = $clog2(BLOCK_WORDS);
    localparam int LOW_BITS  = $clog2(NUM_SETS) + WORD_BITS;
    localparam int TAG_BITS  = WORD_ADDR_BITS - LOW_BITS;

    typedef enum logic [1:0] {IDLE, OUTCOME, WRITE_BACK, ALLOCATE} state_t;

    state_t state_q, state_d;
    logic [WORD_BITS-1:0] count_q, count_d;  // Word inside the block being moved.
    logic phase_q, phase_d;  // Send phase in WRITE_BACK, refill complete in ALLOCATE.
    data_word_t address_q, address_d;
    data_word_t requested_q, requested_d;
    logic [TAG_BITS-1:0] tag_q, tag_d;  // Tag of the block being evicted.
    word_address_t saved_word;
    data_word_t fill_address, evict_address;
    logic last_word;

    assign saved_word    = word_address(address_q);
    assign fill_address  = byte_address({saved_word[WORD_ADDR_BITS-1:WORD_BITS], count_q});
    assign evict_address = byte_address({tag_q, saved_word[LOW_BITS-1:WORD_BITS], count_q});
    assign last_word     = (count_q == WORD_BITS'(BLOCK_WORDS - 1));
    assign controller_idle_o = (state_q == IDLE);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            count_q <= '0;
            phase_q <= 1'b0;
        end else begin
            state_q <= state_d;
            count_q <= count_d;
            phase_q <= phase_d;
        end
    end

    always_ff @(posedge clk_i) begin
        address_q   <= address_d;
        requested_q <= requested_d;
        tag_q       <= tag_d;
    end

    always_comb begin
        state_d     = state_q;
        count_d     = count_q;
        phase_d     = phase_q;
        address_d   = address_q;
        requested_d = requested_q;
        tag_d       = tag_q;

        data_o       = '0;
        valid_o      = 1'b0;
        address_o    = address_i;
        store_data_o = '0;
        load_request_o  = 1'b0;
        store_request_o = 1'b0;
        cache_status_o  = '0;
        enable_write_o  = '0;
        cache_load_request_o  = 1'b0;
        cache_store_request_o = 1'b0;

        case (state_q)
            IDLE: begin
                address_d = address_i;  // Kept for the whole miss.
                count_d   = '0;
                phase_d   = 1'b0;
                if (request_i) begin
                    cache_load_request_o = 1'b1;  // Lookup is captured on this edge.
                    state_d = OUTCOME;
                end
            end

            OUTCOME: begin
                if (cache_hit_i && cache_status_i.valid) begin
                    data_o  = cache_data_i;
                    valid_o = 1'b1;
                    state_d = IDLE;
                end else if (cache_status_i.dirty) begin
                    // Word 0 of the victim is fetched now, so the next cycle can send it.
                    tag_d     = cache_tag_i;
                    address_o = fill_address;
                    cache_load_request_o = 1'b1;
                    phase_d = 1'b1;
                    state_d = WRITE_BACK;
                end else begin
                    state_d = ALLOCATE;  // A clean victim is simply overwritten.
                end
            end

            WRITE_BACK: begin
                address_o    = evict_address;
                store_data_o = cache_data_i;  // Stable until the next fetch.
                if (!phase_q) begin
                    cache_load_request_o = 1'b1;
                    phase_d = 1'b1;
                end else begin
                    store_request_o = ~store_done_i;
                    if (store_done_i) begin
                        phase_d = 1'b0;
                        if (last_word) begin
                            count_d = '0;
                            state_d = ALLOCATE;
                        end else begin
                            count_d = count_q + 1'b1;
                        end
                    end
                end
            end

            ALLOCATE: begin
                address_o      = fill_address;
                store_data_o   = memory_data_i;
                cache_status_o = status_packet_t'{valid: 1'b1, dirty: 1'b0};
                if (phase_q) begin
                    data_o  = requested_q;  // Whole block is resident now.
                    valid_o = 1'b1;
                    phase_d = 1'b0;
                    state_d = IDLE;
                end else begin
                    load_request_o = ~load_done_i;
                    if (load_done_i) begin
                        cache_store_request_o = 1'b1;
                        enable_write_o.data   = 1'b1;
                        if (count_q == '0) begin
                            enable_write_o.tag    = 1'b1;  // Metadata goes in with word 0.
                            enable_write_o.status = 1'b1;
                        end
                        if (saved_word[WORD_BITS-1:0] == count_q) begin
                            requested_d = memory_data_i;
                        end
                        if (last_word) begin
                            phase_d = 1'b1;
                        end else begin
                            count_d = count_q + 1'b1;
                        end
                    end
                end
            end

            default: state_d = IDLE;
        endcase
    end

    // A word comes back one cycle after an idle request or after the last refill word.
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o |-> ($past(request_i && controller_idle_o) || $past(load_done_i && last_word)));

endmodule : load_controller

`default_nettype wire

//--- rtl/cache_memory.sv
`default_nettype none

module cache_memory
    import cpu_pkg::*;
    import cache_pkg::*;
#(
    parameter int NUM_SETS    = 16,
    parameter int BLOCK_WORDS = 4
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  data_word_t address_i,
    input  logic cache_load_request_i,
    input  logic cache_store_request_i,
    input  enable_t enable_write_i,
    input  data_word_t write_data_i,
    input  status_packet_t status_i,
    input  logic controller_idle_i,
    input  logic store_valid_i,
    input  data_word_t store_address_i,
    input  data_word_t store_data_i,
    output logic cache_hit_o,
    output logic [XLEN-BYTE_OFFSET_BITS-$clog2(NUM_SETS)-$clog2(BLOCK_WORDS)-1:0] cache_tag_o,
    output status_packet_t cache_status_o,
    output data_word_t cache_data_o,
    output logic store_ack_o,
    output logic store_hit_o
);

    localparam int LOW_BITS = $clog2(NUM_SETS) + $clog2(BLOCK_WORDS);  // Set and word fields.
    localparam int TAG_BITS = WORD_ADDR_BITS - LOW_BITS;

    word_address_t ctrl_word, store_word, read_word, write_word;
    logic [TAG_BITS-1:0] tag_rd;
    status_packet_t status_rd, status_wr;
    data_word_t data_rd;
    logic store_slot, store_accept, store_match, store_write;

    assign ctrl_word  = word_address(address_i);
    assign store_word = word_address(store_address_i);

    // The store port only gets the arrays while the controller is idle and silent.
    assign store_slot   = controller_idle_i & ~cache_load_request_i & ~cache_store_request_i;
    assign store_accept = store_valid_i & store_slot & ~store_ack_o;  // Once per store.
    assign store_match  = status_rd.valid & (tag_rd == store_word[WORD_ADDR_BITS-1:LOW_BITS]);
    assign store_write  = store_accept & store_match;  // Misses are not allocated.

    assign read_word  = store_slot ? store_word : ctrl_word;
    assign write_word = cache_store_request_i ? ctrl_word : store_word;
    // A store hit always leaves the block valid and dirty.
    assign status_wr  = cache_store_request_i ? status_i
                                              : status_packet_t'{valid: 1'b1, dirty: 1'b1};

    block_ram #(.DEPTH(NUM_SETS), .entry_t(logic [TAG_BITS-1:0])) tag_ram (
        .clk_i, .rst_n_i,
        .write_en_i  (cache_store_request_i & enable_write_i.tag),
        .write_addr_i(write_word[LOW_BITS-1:$clog2(BLOCK_WORDS)]),
        .write_data_i(ctrl_word[WORD_ADDR_BITS-1:LOW_BITS]),
        .read_addr_i (read_word[LOW_BITS-1:$clog2(BLOCK_WORDS)]),
        .read_data_o (tag_rd)
    );

    block_ram #(.DEPTH(NUM_SETS), .entry_t(status_packet_t)) status_ram (
        .clk_i, .rst_n_i,
        .write_en_i  ((cache_store_request_i & enable_write_i.status) | store_write),
        .write_addr_i(write_word[LOW_BITS-1:$clog2(BLOCK_WORDS)]),
        .write_data_i(status_wr),
        .read_addr_i (read_word[LOW_BITS-1:$clog2(BLOCK_WORDS)]),
        .read_data_o (status_rd)
    );

    block_ram #(.DEPTH(NUM_SETS * BLOCK_WORDS), .entry_t(data_word_t)) data_ram (
        .clk_i, .rst_n_i,
        .write_en_i  ((cache_store_request_i & enable_write_i.data) | store_write),
        .write_addr_i(write_word[LOW_BITS-1:0]),
        .write_data_i(cache_store_request_i ? write_data_i : store_data_i),
        .read_addr_i (read_word[LOW_BITS-1:0]),
        .read_data_o (data_rd)
    );

    // The lookup is held until the next controller load request.
    always_ff @(posedge clk_i) begin
        if (cache_load_request_i) begin
            cache_hit_o    <= (tag_rd == ctrl_word[WORD_ADDR_BITS-1:LOW_BITS]);
            cache_tag_o    <= tag_rd;
            cache_status_o <= status_rd;
            cache_data_o   <= data_rd;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            store_ack_o <= 1'b0;
            store_hit_o <= 1'b0;
        end else begin
            store_ack_o <= store_accept;  // Acknowledge one cycle after acceptance.
            store_hit_o <= store_write;
        end
    end

    // The controller either reads or writes the arrays, never both in one cycle.
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(cache_load_request_i && cache_store_request_i));

endmodule : cache_memory

`default_nettype wire

//--- rtl/block_ram.sv
`default_nettype none

module block_ram #(
    parameter int  DEPTH   = 16,
    parameter type entry_t = logic
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     write_en_i,
    input  logic [$clog2(DEPTH)-1:0] write_addr_i,
    input  entry_t                   write_data_i,
    input  logic [$clog2(DEPTH)-1:0] read_addr_i,
    output entry_t                   read_data_o
);

    entry_t mem [DEPTH];  // Flop storage, one entry per address.

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            // Clearing everything leaves every status entry invalid and clean.
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (write_en_i) begin
            mem[write_addr_i] <= write_data_i;
        end
    end

    assign read_data_o = mem[read_addr_i];  // Read is combinational.

    // A write past the last entry would point at a missing set.
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        write_en_i |-> (int'(write_addr_i) < DEPTH));

endmodule : block_ram

`default_nettype wire

//--- rtl/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // Status of one cache block.
    typedef struct packed {
        logic valid;  // Block holds memory contents.
        logic dirty;  // Block differs from memory and must be written back.
    } status_packet_t;

    // Write enables for the three cache arrays.
    typedef struct packed {
        logic tag;
        logic status;
        logic data;
    } enable_t;

endpackage : cache_pkg

`default_nettype wire

//--- rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int XLEN = 32;             // Width of a data word and of an address.
    localparam int BYTE_OFFSET_BITS = 2;  // Byte offset inside one word.

    // Width of an address once the byte offset is stripped.
    localparam int WORD_ADDR_BITS = XLEN - BYTE_OFFSET_BITS;

    typedef logic [XLEN-1:0] data_word_t;
    typedef logic [WORD_ADDR_BITS-1:0] word_address_t;

    // Drops the byte offset, leaving tag, set and word fields packed together.
    function automatic word_address_t word_address(input data_word_t address);
        return address[XLEN-1:BYTE_OFFSET_BITS];
    endfunction

    // Rebuilds a word-aligned byte address from its word address.
    function automatic data_word_t byte_address(input word_address_t word);
        return {word, {BYTE_OFFSET_BITS{1'b0}}};
    endfunction

endpackage : cpu_pkg

`default_nettype wire
